//--- memory_game_cfg.svh
// Memory game configuration
`ifndef MEMORY_GAME_CFG_SVH
`define MEMORY_GAME_CFG_SVH

// Sequence RAM depth and round counter width
`define MG_ADDR_W 4

// Rounds played per level
`define MG_ROUNDS_SHORT 8
`define MG_ROUNDS_LONG 16

// Clock cycles allowed between two presses
`define MG_TIMEOUT_LONG 80
`define MG_TIMEOUT_SHORT 40

// LED timing for each shown move
`define MG_LED_ON 8
// Must be at least 2, the last dark cycle is the step between moves
`define MG_LED_OFF 4

// Half period of the buzzer tone
`define MG_BUZZER_DIV 2

`endif

//--- memory_game_pkg.sv
// Memory game types
`include "memory_game_cfg.svh"

package memory_game_pkg;

    // One-hot button word, one bit per colored button
    typedef logic [3:0] move_t;

    // Sequence address and round number
    typedef logic [`MG_ADDR_W-1:0] addr_t;

    // Control FSM states, st_idle shows as digit 0
    typedef enum logic [3:0] {
        st_idle, st_prep, st_wait_new, st_write_new,
        st_show_on, st_show_off, st_show_next, st_prep_play,
        st_wait_play, st_check, st_next_addr, st_next_round,
        st_won, st_lost
    } state_t;

endpackage

//--- hexa7seg.sv
// Hex digit to seven segment decoder
module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // Segments active high, bit 0 is a up to bit 6 is g
    always_comb begin
        case (hexa)
            4'h0:    display = 7'h3F;
            4'h1:    display = 7'h06;
            4'h2:    display = 7'h5B;
            4'h3:    display = 7'h4F;
            4'h4:    display = 7'h66;
            4'h5:    display = 7'h6D;
            4'h6:    display = 7'h7D;
            4'h7:    display = 7'h07;
            4'h8:    display = 7'h7F;
            4'h9:    display = 7'h6F;
            4'hA:    display = 7'h77;
            4'hB:    display = 7'h7C;
            4'hC:    display = 7'h39;
            4'hD:    display = 7'h5E;
            4'hE:    display = 7'h79;
            default: display = 7'h71;
        endcase
    end

endmodule

//--- game_datapath.sv
// Memory game datapath
`include "memory_game_cfg.svh"

module game_datapath import memory_game_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  move_t      botoes,
    input  logic       nivel_jogadas,
    input  logic       nivel_tempo,
    input  logic       zera_r,
    input  logic       conta_r,
    input  logic       zera_e,
    input  logic       conta_e,
    input  logic       registra_n,
    input  logic       zera_tempo,
    input  logic       conta_tempo,
    input  logic       zera_show,
    input  logic       conta_show,
    input  logic       grava_m,
    input  logic       ativa_leds_mem,
    input  logic       ativa_leds_jog,
    input  logic       toca,
    output logic       jogada_feita,
    output logic       jogada_correta,
    output logic       endereco_igual_rodada,
    output logic       fim_rodadas,
    output logic       fim_show_on,
    output logic       fim_show_off,
    output logic       fim_tempo,
    output move_t      leds,
    output logic       pulso_buzzer,
    output logic [3:0] db_contagem,
    output logic [3:0] db_rodada,
    output logic [3:0] db_memoria,
    output logic [3:0] db_jogada,
    output logic       db_timeout_cond
);

    localparam int TEMPO_W = $clog2(`MG_TIMEOUT_LONG + 1);
    localparam int SHOW_W  = $clog2(`MG_LED_ON + `MG_LED_OFF + 1);
    localparam int BUZ_W   = $clog2(`MG_BUZZER_DIV + 1);

    addr_t              rodada;
    addr_t              endereco;
    logic               nivel_jogadas_reg;
    logic               nivel_tempo_reg;
    move_t              botoes_q;
    move_t              jogada;
    move_t              mem [2**`MG_ADDR_W];
    move_t              mem_dado;
    logic [TEMPO_W-1:0] tempo_cnt;
    logic [TEMPO_W-1:0] tempo_limite;
    logic [SHOW_W-1:0]  show_cnt;
    logic [BUZ_W-1:0]   buz_cnt;

    // Round and address counters, clear wins over count
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rodada   <= '0;
            endereco <= '0;
        end else begin
            if (zera_r)
                rodada <= '0;
            else if (conta_r)
                rodada <= rodada + 1'b1;
            if (zera_e)
                endereco <= '0;
            else if (conta_e)
                endereco <= endereco + 1'b1;
        end
    end

    // Levels are sampled once per game
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            nivel_jogadas_reg <= 1'b0;
            nivel_tempo_reg   <= 1'b0;
        end else if (registra_n) begin
            nivel_jogadas_reg <= nivel_jogadas;
            nivel_tempo_reg   <= nivel_tempo;
        end
    end

    // Press is the first nonzero word after an idle cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            botoes_q     <= '0;
            jogada_feita <= 1'b0;
        end else begin
            botoes_q     <= botoes;
            jogada_feita <= (botoes != '0) && (botoes_q == '0);
        end
    end

    // Move register loads together with the press pulse
    always_ff @(posedge clock) begin
        if ((botoes != '0) && (botoes_q == '0))
            jogada <= botoes;
    end

    // Sequence RAM, written at the round, read at the address
    always_ff @(posedge clock) begin
        if (grava_m)
            mem[rodada] <= jogada;
    end

    assign mem_dado = mem[endereco];

    // Timeout timer
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            tempo_cnt <= '0;
        else if (zera_tempo)
            tempo_cnt <= '0;
        else if (conta_tempo && !fim_tempo)
            tempo_cnt <= tempo_cnt + 1'b1;
    end

    assign tempo_limite = nivel_tempo_reg ? TEMPO_W'(`MG_TIMEOUT_SHORT)
                                          : TEMPO_W'(`MG_TIMEOUT_LONG);

    // LED timer for the show phase
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            show_cnt <= '0;
        else if (zera_show)
            show_cnt <= '0;
        else if (conta_show)
            show_cnt <= show_cnt + 1'b1;
    end

    // Buzzer square wave while toca is held
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            buz_cnt      <= '0;
            pulso_buzzer <= 1'b0;
        end else if (!toca) begin
            buz_cnt      <= '0;
            pulso_buzzer <= 1'b0;
        end else if (buz_cnt == BUZ_W'(`MG_BUZZER_DIV - 1)) begin
            buz_cnt      <= '0;
            pulso_buzzer <= ~pulso_buzzer;
        end else begin
            buz_cnt <= buz_cnt + 1'b1;
        end
    end

    // Conditions back to the FSM
    assign jogada_correta        = (jogada == mem_dado);
    assign endereco_igual_rodada = (endereco == rodada);
    assign fim_rodadas = nivel_jogadas_reg ? (rodada == addr_t'(`MG_ROUNDS_LONG - 1))
                                           : (rodada == addr_t'(`MG_ROUNDS_SHORT - 1));
    assign fim_tempo   = (tempo_cnt == tempo_limite);
    // Flags mark the last lit and the last but one dark cycle
    assign fim_show_on  = (show_cnt == SHOW_W'(`MG_LED_ON - 1));
    assign fim_show_off = (show_cnt == SHOW_W'(`MG_LED_ON + `MG_LED_OFF - 2));

    // LED source select
    always_comb begin
        if (ativa_leds_mem)
            leds = mem_dado;
        else if (ativa_leds_jog)
            leds = botoes;
        else
            leds = '0;
    end

    assign db_contagem     = endereco;
    assign db_rodada       = rodada;
    assign db_memoria      = mem_dado;
    assign db_jogada       = jogada;
    assign db_timeout_cond = fim_tempo;

endmodule

//--- game_control.sv
// Memory game control FSM
module game_control import memory_game_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       iniciar,
    input  logic       jogada_feita,
    input  logic       jogada_correta,
    input  logic       endereco_igual_rodada,
    input  logic       fim_rodadas,
    input  logic       fim_show_on,
    input  logic       fim_show_off,
    input  logic       fim_tempo,
    output logic       zera_r,
    output logic       conta_r,
    output logic       zera_e,
    output logic       conta_e,
    output logic       registra_n,
    output logic       zera_tempo,
    output logic       conta_tempo,
    output logic       zera_show,
    output logic       conta_show,
    output logic       grava_m,
    output logic       ativa_leds_mem,
    output logic       ativa_leds_jog,
    output logic       toca,
    output logic       ganhou,
    output logic       perdeu,
    output logic       pronto,
    output logic       vez_jogador,
    output logic       nova_jogada,
    output logic [3:0] db_estado,
    output logic       db_timeout
);

    state_t estado;
    state_t proximo;
    logic   esperando;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            estado <= st_idle;
        else
            estado <= proximo;
    end

    assign esperando = (estado == st_wait_new) || (estado == st_wait_play);

    // Timeout flag, cleared when a new game starts
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            db_timeout <= 1'b0;
        else if (estado == st_prep)
            db_timeout <= 1'b0;
        else if (esperando && fim_tempo)
            db_timeout <= 1'b1;
    end

    // Next state
    always_comb begin
        proximo = estado;
        case (estado)
            st_idle, st_won, st_lost:
                if (iniciar) proximo = st_prep;
            st_prep:       proximo = st_wait_new;
            st_wait_new:
                if (fim_tempo)
                    proximo = st_lost;
                else if (jogada_feita)
                    proximo = st_write_new;
            st_write_new:  proximo = st_show_on;
            st_show_on:
                if (fim_show_on) proximo = st_show_off;
            st_show_off:
                if (fim_show_off) proximo = st_show_next;
            st_show_next:
                proximo = endereco_igual_rodada ? st_prep_play : st_show_on;
            st_prep_play:  proximo = st_wait_play;
            st_wait_play:
                if (fim_tempo)
                    proximo = st_lost;
                else if (jogada_feita)
                    proximo = st_check;
            st_check:
                if (!jogada_correta)
                    proximo = st_lost;
                else if (!endereco_igual_rodada)
                    proximo = st_next_addr;
                else if (fim_rodadas)
                    proximo = st_won;
                else
                    proximo = st_next_round;
            st_next_addr:  proximo = st_wait_play;
            st_next_round: proximo = st_wait_new;
            default:       proximo = st_idle;
        endcase
    end

    // Moore outputs
    always_comb begin
        zera_r         = (estado == st_prep);
        registra_n     = (estado == st_prep);
        conta_r        = (estado == st_next_round);
        zera_e         = (estado == st_prep) || (estado == st_write_new)
                         || (estado == st_prep_play);
        // Address steps after each shown move and each correct move
        conta_e        = (estado == st_show_next) || (estado == st_next_addr);
        zera_tempo     = (estado == st_prep) || (estado == st_prep_play)
                         || (estado == st_next_addr) || (estado == st_next_round);
        conta_tempo    = esperando;
        zera_show      = (estado == st_write_new) || (estado == st_show_next);
        conta_show     = (estado == st_show_on) || (estado == st_show_off);
        grava_m        = (estado == st_write_new);
        ativa_leds_mem = (estado == st_show_on);
        toca           = (estado == st_show_on);
        ativa_leds_jog = esperando;
        vez_jogador    = esperando;
        nova_jogada    = (estado == st_wait_new);
        ganhou         = (estado == st_won);
        perdeu         = (estado == st_lost);
        pronto         = (estado == st_won) || (estado == st_lost);
    end

    assign db_estado = estado;

endmodule

//--- memory_game.sv
// Memory game top level
module memory_game import memory_game_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       iniciar,
    input  move_t      botoes,
    input  logic       nivel_jogadas,
    input  logic       nivel_tempo,
    output logic       ganhou,
    output logic       perdeu,
    output logic       pronto,
    output logic       vez_jogador,
    output logic       nova_jogada,
    output move_t      leds,
    output logic       pulso_buzzer,
    output logic       db_timeout,
    output logic [6:0] db_contagem,
    output logic [6:0] db_memoria,
    output logic [6:0] db_estado,
    output logic [6:0] db_jogada,
    output logic [6:0] db_rodada
);

    // Control signals
    logic zera_r, conta_r, zera_e, conta_e, registra_n;
    logic zera_tempo, conta_tempo, zera_show, conta_show;
    logic grava_m, ativa_leds_mem, ativa_leds_jog, toca;
    // Condition signals
    logic jogada_feita, jogada_correta, endereco_igual_rodada, fim_rodadas;
    logic fim_show_on, fim_show_off, fim_tempo;
    // Raw debug nibbles
    logic [3:0] s_contagem, s_memoria, s_estado, s_jogada, s_rodada;

    game_datapath u_datapath (
        .clock                 ( clock                 ),
        .rst_n                 ( rst_n                 ),
        .botoes                ( botoes                ),
        .nivel_jogadas         ( nivel_jogadas         ),
        .nivel_tempo           ( nivel_tempo           ),
        .zera_r                ( zera_r                ),
        .conta_r               ( conta_r               ),
        .zera_e                ( zera_e                ),
        .conta_e               ( conta_e               ),
        .registra_n            ( registra_n            ),
        .zera_tempo            ( zera_tempo            ),
        .conta_tempo           ( conta_tempo           ),
        .zera_show             ( zera_show             ),
        .conta_show            ( conta_show            ),
        .grava_m               ( grava_m               ),
        .ativa_leds_mem        ( ativa_leds_mem        ),
        .ativa_leds_jog        ( ativa_leds_jog        ),
        .toca                  ( toca                  ),
        .jogada_feita          ( jogada_feita          ),
        .jogada_correta        ( jogada_correta        ),
        .endereco_igual_rodada ( endereco_igual_rodada ),
        .fim_rodadas           ( fim_rodadas           ),
        .fim_show_on           ( fim_show_on           ),
        .fim_show_off          ( fim_show_off          ),
        .fim_tempo             ( fim_tempo             ),
        .leds                  ( leds                  ),
        .pulso_buzzer          ( pulso_buzzer          ),
        .db_contagem           ( s_contagem            ),
        .db_rodada             ( s_rodada              ),
        .db_memoria            ( s_memoria             ),
        .db_jogada             ( s_jogada              ),
        // Probe point only, not routed to a board pin
        .db_timeout_cond       (                       )
    );

    game_control u_control (
        .clock                 ( clock                 ),
        .rst_n                 ( rst_n                 ),
        .iniciar               ( iniciar               ),
        .jogada_feita          ( jogada_feita          ),
        .jogada_correta        ( jogada_correta        ),
        .endereco_igual_rodada ( endereco_igual_rodada ),
        .fim_rodadas           ( fim_rodadas           ),
        .fim_show_on           ( fim_show_on           ),
        .fim_show_off          ( fim_show_off          ),
        .fim_tempo             ( fim_tempo             ),
        .zera_r                ( zera_r                ),
        .conta_r               ( conta_r               ),
        .zera_e                ( zera_e                ),
        .conta_e               ( conta_e               ),
        .registra_n            ( registra_n            ),
        .zera_tempo            ( zera_tempo            ),
        .conta_tempo           ( conta_tempo           ),
        .zera_show             ( zera_show             ),
        .conta_show            ( conta_show            ),
        .grava_m               ( grava_m               ),
        .ativa_leds_mem        ( ativa_leds_mem        ),
        .ativa_leds_jog        ( ativa_leds_jog        ),
        .toca                  ( toca                  ),
        .ganhou                ( ganhou                ),
        .perdeu                ( perdeu                ),
        .pronto                ( pronto                ),
        .vez_jogador           ( vez_jogador           ),
        .nova_jogada           ( nova_jogada           ),
        .db_estado             ( s_estado              ),
        .db_timeout            ( db_timeout            )
    );

    // Debug displays
    hexa7seg u_hex_contagem ( .hexa ( s_contagem ), .display ( db_contagem ) );
    hexa7seg u_hex_memoria  ( .hexa ( s_memoria  ), .display ( db_memoria  ) );
    hexa7seg u_hex_estado   ( .hexa ( s_estado   ), .display ( db_estado   ) );
    hexa7seg u_hex_jogada   ( .hexa ( s_jogada   ), .display ( db_jogada   ) );
    hexa7seg u_hex_rodada   ( .hexa ( s_rodada   ), .display ( db_rodada   ) );

endmodule

//--- tb_memory_game.sv
// Memory game testbench
`include "memory_game_cfg.svh"

module tb_memory_game import memory_game_pkg::*; ;

    // All tests together take a few thousand cycles
    localparam int cycle_limit = 20000;

    logic       clock;
    logic       rst_n;
    logic       iniciar;
    move_t      botoes;
    logic       nivel_jogadas;
    logic       nivel_tempo;
    logic       ganhou;
    logic       perdeu;
    logic       pronto;
    logic       vez_jogador;
    logic       nova_jogada;
    move_t      leds;
    logic       pulso_buzzer;
    logic       db_timeout;
    logic [6:0] db_contagem;
    logic [6:0] db_memoria;
    logic [6:0] db_estado;
    logic [6:0] db_jogada;
    logic [6:0] db_rodada;

    integer seed = 32'h9246;
    move_t  model [16];
    string  test_name;
    int     cycles = 0;
    int     r;

    memory_game UUT (
        .clock         ( clock         ),
        .rst_n         ( rst_n         ),
        .iniciar       ( iniciar       ),
        .botoes        ( botoes        ),
        .nivel_jogadas ( nivel_jogadas ),
        .nivel_tempo   ( nivel_tempo   ),
        .ganhou        ( ganhou        ),
        .perdeu        ( perdeu        ),
        .pronto        ( pronto        ),
        .vez_jogador   ( vez_jogador   ),
        .nova_jogada   ( nova_jogada   ),
        .leds          ( leds          ),
        .pulso_buzzer  ( pulso_buzzer  ),
        .db_timeout    ( db_timeout    ),
        .db_contagem   ( db_contagem   ),
        .db_memoria    ( db_memoria    ),
        .db_estado     ( db_estado     ),
        .db_jogada     ( db_jogada     ),
        .db_rodada     ( db_rodada     )
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("TEST FAILED");
            $fatal(1, "Timeout after %0d cycles, the game stopped responding", cycle_limit);
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s (%s): expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Segments a to g on bits 0 to 6
    function automatic logic [6:0] seg_code(input logic [3:0] d);
        case (d)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic move_t random_move();
        return move_t'(4'b0001 << ($unsigned($random(seed)) % 4));
    endfunction

    // Inputs change 2 units after the rising edge
    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic start_game(input logic jogadas, input logic tempo);
        nivel_jogadas = jogadas;
        nivel_tempo   = tempo;
        iniciar       = 1'b1;
        step();
        iniciar = 1'b0;
        // One cycle in the prep state, results already cleared
        check_value("ganhou after start", 0, ganhou);
        check_value("perdeu after start", 0, perdeu);
        check_value("pronto after start", 0, pronto);
        step();
        check_value("nova_jogada after start", 1, nova_jogada);
        check_value("vez_jogador after start", 1, vez_jogador);
        check_value("db_timeout after start", 0, db_timeout);
        check_value("db_rodada after start", seg_code(4'h0), db_rodada);
        check_value("db_contagem after start", seg_code(4'h0), db_contagem);
    endtask

    task automatic press_button(input move_t m);
        while (!vez_jogador)
            step();
        botoes = m;
        step();
        check_value("leds follow buttons", m, leds);
        check_value("move display", seg_code(m), db_jogada);
        botoes = '0;
        step();
    endtask

    task automatic watch_show(input int last);
        int   i;
        int   lit;
        int   dark;
        int   toggles;
        logic buz_q;
        for (i = 0; i <= last; i++) begin
            dark = 0;
            while (leds == '0) begin
                dark++;
                step();
            end
            if (i > 0)
                check_value("dark cycles between moves", `MG_LED_OFF, dark);
            lit     = 0;
            toggles = 0;
            buz_q   = pulso_buzzer;
            while (leds != '0) begin
                check_value("shown move", model[i], leds);
                check_value("address display", seg_code(4'(i)), db_contagem);
                check_value("memory display", seg_code(model[i]), db_memoria);
                if (pulso_buzzer != buz_q)
                    toggles++;
                buz_q = pulso_buzzer;
                lit++;
                step();
            end
            check_value("lit cycles per move", `MG_LED_ON, lit);
            check_value("buzzer toggles while lit", 1, toggles > 0);
        end
    endtask

    // New move, show, then repeat; wrong_at picks a move to get wrong
    task automatic play_round(input int rnd, input int wrong_at);
        int i;
        model[rnd] = random_move();
        press_button(model[rnd]);
        watch_show(rnd);
        for (i = 0; i <= rnd && i != wrong_at; i++)
            press_button(model[i]);
        if (wrong_at >= 0 && wrong_at <= rnd)
            press_button({model[wrong_at][2:0], model[wrong_at][3]});
    endtask

    initial begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        iniciar       = 1'b0;
        botoes        = '0;
        nivel_jogadas = 1'b0;
        nivel_tempo   = 1'b0;
        test_name     = "reset";
        repeat (16) @(posedge clock);
        #2 rst_n = 1'b1;
        step();
        check_value("ganhou", 0, ganhou);
        check_value("perdeu", 0, perdeu);
        check_value("pronto", 0, pronto);
        check_value("vez_jogador", 0, vez_jogador);
        check_value("nova_jogada", 0, nova_jogada);
        check_value("pulso_buzzer", 0, pulso_buzzer);
        check_value("db_timeout", 0, db_timeout);
        check_value("leds", 0, leds);
        check_value("db_estado", seg_code(4'h0), db_estado);

        test_name = "short game won";
        start_game(1'b0, 1'b0);
        for (r = 0; r < `MG_ROUNDS_SHORT; r++)
            play_round(r, -1);
        while (!pronto)
            step();
        check_value("ganhou", 1, ganhou);
        check_value("perdeu", 0, perdeu);
        check_value("db_rodada", seg_code(`MG_ROUNDS_SHORT - 1), db_rodada);

        test_name = "wrong move";
        start_game(1'b0, 1'b0);
        play_round(0, -1);
        play_round(1, -1);
        play_round(2, 2);
        while (!pronto)
            step();
        check_value("perdeu", 1, perdeu);
        check_value("ganhou", 0, ganhou);
        check_value("db_timeout", 0, db_timeout);

        test_name = "short timeout";
        start_game(1'b0, 1'b1);
        repeat (60) step();
        check_value("perdeu", 1, perdeu);
        check_value("db_timeout", 1, db_timeout);

        test_name = "long timeout";
        start_game(1'b0, 1'b0);
        repeat (60) step();
        check_value("perdeu", 0, perdeu);
        check_value("vez_jogador", 1, vez_jogador);
        play_round(0, -1);
        while (!vez_jogador && !pronto)
            step();
        check_value("perdeu after round", 0, perdeu);
        // Let the long limit expire so the game can restart
        while (!pronto)
            step();
        check_value("db_timeout", 1, db_timeout);

        test_name = "long level";
        start_game(1'b1, 1'b0);
        for (r = 0; r < `MG_ROUNDS_LONG; r++) begin
            play_round(r, -1);
            if (r == `MG_ROUNDS_SHORT - 1) begin
                while (!vez_jogador && !pronto)
                    step();
                check_value("ganhou after short count", 0, ganhou);
                check_value("pronto after short count", 0, pronto);
            end
        end
        while (!pronto)
            step();
        check_value("ganhou", 1, ganhou);
        check_value("db_rodada", seg_code(`MG_ROUNDS_LONG - 1), db_rodada);

        test_name = "restart";
        start_game(1'b0, 1'b0);

        $display("TEST OK");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
memory_game_pkg.sv
hexa7seg.sv
game_datapath.sv
game_control.sv
memory_game.sv
tb_memory_game.sv

//--- Bender.yml
package:
  name: memory_game

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - memory_game_pkg.sv
      - hexa7seg.sv
      - game_datapath.sv
      - game_control.sv
      - memory_game.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_memory_game.sv
